// ==== merge_defs.svh ====
`ifndef MERGE_DEFS_SVH
`define MERGE_DEFS_SVH

// payload width of one lane word
`define DATA_W 16

// words held by each lane FIFO
`define LANE_DEPTH 4

// occupancy count covers 0 .. LANE_DEPTH inclusive
`define LANE_CNT_W 3

// read/write pointer width, indexes 0 .. LANE_DEPTH-1
`define LANE_PTR_W 2

`endif

// ==== arb_pkg.sv ====
package arb_pkg;

  // lane number, two lanes only
  typedef logic lane_id_t;

  // one-hot grant, bit i set when lane i wins
  typedef logic [1:0] grant_t;

  // lane numbers by name
  localparam lane_id_t LANE0 = 1'b0;
  localparam lane_id_t LANE1 = 1'b1;

endpackage

// ==== stream_pkg.sv ====
`include "merge_defs.svh"

package stream_pkg;

  // word as it travels through a lane
  typedef struct packed {
    logic [`DATA_W-1:0] data;
  } lane_flit_t;

  // merged word, tagged with the lane it came from
  typedef struct packed {
    arb_pkg::lane_id_t  src;  // msb of the 17 bit word
    logic [`DATA_W-1:0] data;
  } out_flit_t;

endpackage

// ==== lane_fifo.sv ====
`timescale 1ns/100ps
`include "merge_defs.svh"

module lane_fifo (
  input  logic                  clk,
  input  logic                  rst,

  // write side
  input  logic                  in_valid,
  input  stream_pkg::lane_flit_t in_flit,
  output logic                  in_stall,

  // read side
  output logic                  out_valid,
  output stream_pkg::lane_flit_t out_flit,
  input  logic                  out_stall
);

  import stream_pkg::*;

  lane_flit_t                 mem [`LANE_DEPTH];
  logic [`LANE_PTR_W-1:0]     rd_ptr;
  logic [`LANE_PTR_W-1:0]     wr_ptr;
  logic [`LANE_CNT_W-1:0]     count;
  logic [`LANE_CNT_W-1:0]     count_n;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  assign full  = (count == `LANE_CNT_W'(`LANE_DEPTH));
  assign empty = (count == '0);

  // a full FIFO never takes a word even when it is read this cycle
  assign in_stall = full;
  assign wr_en    = in_valid & ~full;

  assign out_valid = ~empty;
  assign out_flit  = mem[rd_ptr];  // head of queue
  assign rd_en     = out_valid & ~out_stall;

  always_comb begin
    case ({wr_en, rd_en})
      2'b10:   count_n = count + 1'b1;
      2'b01:   count_n = count - 1'b1;
      default: count_n = count;  // idle or read and write together
    endcase
  end

  // pointer and count state
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      count <= count_n;
      if (wr_en) begin
        if (wr_ptr == `LANE_PTR_W'(`LANE_DEPTH - 1))
          wr_ptr <= '0;
        else
          wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        if (rd_ptr == `LANE_PTR_W'(`LANE_DEPTH - 1))
          rd_ptr <= '0;
        else
          rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_ptr] <= in_flit;
  end

  a_count_bound: assert property (
    @(posedge clk) disable iff (rst)
    count <= `LANE_CNT_W'(`LANE_DEPTH)
  ) else $error("lane_fifo count above depth: %0d", count);

  // pointers that meet with data present mean a full FIFO, never an empty one
  a_no_valid_when_empty: assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && (rd_ptr == wr_ptr)) |-> full
  ) else $error("lane_fifo out_valid while the pointers show empty");

endmodule

// ==== stall_buf.sv ====
`timescale 1ns/100ps

module stall_buf (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  in_valid,
  input  stream_pkg::out_flit_t in_flit,
  output logic                  in_stall,

  output logic                  out_valid,
  output stream_pkg::out_flit_t out_flit,
  input  logic                  out_stall
);

  import stream_pkg::*;

  logic      stall_q;     // out_stall seen one cycle late
  logic      skid_valid;
  out_flit_t skid_flit;
  logic      skid_load;
  logic      skid_drain;

  // upstream only learns of the stall from the register
  assign in_stall = stall_q;

  // skid word always goes out before anything new
  assign out_valid = skid_valid | (in_valid & ~stall_q);
  assign out_flit  = skid_valid ? skid_flit : in_flit;

  // word was accepted upstream but downstream already stalls
  assign skid_load  = in_valid & ~stall_q & out_stall;
  assign skid_drain = skid_valid & ~out_stall;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      stall_q    <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      stall_q <= out_stall;
      if (skid_load)
        skid_valid <= 1'b1;
      else if (skid_drain)
        skid_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (skid_load)
      skid_flit <= in_flit;
  end

  // full skid implies stall_q was raised, so no second word can slip in
  a_skid_no_overwrite: assert property (
    @(posedge clk) disable iff (rst)
    skid_valid |-> !skid_load
  ) else $error("stall_buf skid register overwritten");

endmodule

// ==== rr_arbiter.sv ====
`timescale 1ns/100ps

module rr_arbiter (
  input  logic                        clk,
  input  logic                        rst,

  // lane side
  input  logic [1:0]                  req_valid,
  input  stream_pkg::lane_flit_t [1:0] req_flit,
  output logic [1:0]                  req_stall,

  // merged stream
  output logic                        out_valid,
  output stream_pkg::out_flit_t       out_flit,
  input  logic                        out_stall
);

  import arb_pkg::*;
  import stream_pkg::*;

  lane_id_t  ptr;         // lane with priority this cycle
  grant_t    grant;
  lane_id_t  sel;
  logic      advance;

  logic      stage_valid;
  out_flit_t stage_flit;
  logic      buf_stall;

  // stage may take a word when empty or when its word leaves this cycle
  assign advance = ~stage_valid | ~buf_stall;

  always_comb begin
    grant = '0;
    if (advance) begin
      if (req_valid[ptr])
        grant[ptr] = 1'b1;
      else if (req_valid[~ptr])
        grant[~ptr] = 1'b1;
    end
  end

  assign sel = grant[LANE1] ? LANE1 : LANE0;

  // losers and everyone while the stage is blocked
  assign req_stall = req_valid & ~grant;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ptr         <= LANE0;
      stage_valid <= 1'b0;
    end else begin
      if (|grant)
        ptr <= ~sel;  // move past the lane just served
      if (advance)
        stage_valid <= |grant;
    end
  end

  // payload register, tagged with its lane
  always_ff @(posedge clk) begin
    if (|grant) begin
      stage_flit.src  <= sel;
      stage_flit.data <= req_flit[sel].data;
    end
  end

  stall_buf u_stall_buf (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (stage_valid),
    .in_flit   (stage_flit),
    .in_stall  (buf_stall),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_stall (out_stall)
  );

  a_grant_onehot: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(grant)
  ) else $error("rr_arbiter grant not one-hot: %b", grant);

  // with both lanes waiting, the next grant goes to the other lane
  a_alternate: assert property (
    @(posedge clk) disable iff (rst)
    (grant[0] && req_valid[1]) ##1 (&req_valid && advance) |-> grant[1]
  ) else $error("rr_arbiter did not alternate");

endmodule

// ==== lane_merge_top.sv ====
`timescale 1ns/100ps

module lane_merge_top (
  input  logic                   clk,
  input  logic                   rst,

  // lane 0
  input  logic                   in0_valid,
  input  stream_pkg::lane_flit_t in0_flit,
  output logic                   in0_stall,

  // lane 1
  input  logic                   in1_valid,
  input  stream_pkg::lane_flit_t in1_flit,
  output logic                   in1_stall,

  // merged output
  output logic                   out_valid,
  output stream_pkg::out_flit_t  out_flit,
  input  logic                   out_stall
);

  import stream_pkg::*;

  logic [1:0]       req_valid;
  lane_flit_t [1:0] req_flit;
  logic [1:0]       req_stall;

  lane_fifo u_lane0 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in0_valid),
    .in_flit   (in0_flit),
    .in_stall  (in0_stall),
    .out_valid (req_valid[0]),
    .out_flit  (req_flit[0]),
    .out_stall (req_stall[0])
  );

  lane_fifo u_lane1 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in1_valid),
    .in_flit   (in1_flit),
    .in_stall  (in1_stall),
    .out_valid (req_valid[1]),
    .out_flit  (req_flit[1]),
    .out_stall (req_stall[1])
  );

  rr_arbiter u_arb (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_flit  (req_flit),
    .req_stall (req_stall),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_stall (out_stall)
  );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  localparam int PERIOD     = 100;  // ns
  localparam int RST_CYCLES = 2;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // released on a falling edge, clear of the rising edges
  initial begin
    rst = 1'b1;
    #(PERIOD * RST_CYCLES);
    rst = 1'b0;
  end

endmodule

// ==== lane_merge_tb.sv ====
`timescale 1ns/100ps
`include "merge_defs.svh"

module lane_merge_tb;

  import stream_pkg::*;

  localparam int CLK_PERIOD  = 100;  // ns as in tb_clk_gen
  localparam int NUM_TESTS   = 5;
  localparam int TEST_CYCLES = 400;  // cycle budget of one test
  localparam int DRAIN_LIMIT = 200;

  logic       clk;
  logic       rst;
  logic       in0_valid;
  lane_flit_t in0_flit;
  logic       in0_stall;
  logic       in1_valid;
  lane_flit_t in1_flit;
  logic       in1_stall;
  logic       out_valid;
  out_flit_t  out_flit;
  logic       out_stall;

  logic [`DATA_W-1:0] exp_q0[$];   // words accepted on lane 0 and not yet out
  logic [`DATA_W-1:0] exp_q1[$];
  logic [`DATA_W-1:0] send_q0[$];  // words still to be offered
  logic [`DATA_W-1:0] send_q1[$];
  logic               src_log[$];  // lane of every output word in order
  int                 err_count;
  int                 out_count;
  logic               acc0;
  logic               acc1;
  logic [31:0]        lcg_state;

  tb_clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  lane_merge_top uut (
    .clk       (clk),
    .rst       (rst),
    .in0_valid (in0_valid),
    .in0_flit  (in0_flit),
    .in0_stall (in0_stall),
    .in1_valid (in1_valid),
    .in1_flit  (in1_flit),
    .in1_stall (in1_stall),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_stall (out_stall)
  );

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [`DATA_W-1:0] rand_data();
    logic [31:0] r;
    r = rand_next();
    return r[31 -: `DATA_W];  // upper bits are the better ones of an LCG
  endfunction

  task automatic check_out_flit(input string name, input out_flit_t got, input out_flit_t want);
    if (got !== want) begin
      $display("** Error: %s got %h expected %h at %0t", name, got, want, $time);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("** Error: %s got %h expected %h at %0t", name, got, want, $time);
      err_count++;
    end
  endtask

  task automatic check_int(input string name, input int got, input int want);
    if (got != want) begin
      $display("** Error: %s got %h expected %h at %0t", name, got, want, $time);
      err_count++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s at %0t", msg, $time);
    err_count++;
  endtask

  // called on a falling edge to score what moves at the next rising edge and step one cycle
  task automatic tick();
    out_flit_t want;
    want = '0;
    if (out_valid && !out_stall) begin
      out_count++;
      src_log.push_back(out_flit.src);
      if (out_flit.src === 1'b0 && exp_q0.size() != 0) begin
        want.src  = 1'b0;
        want.data = exp_q0.pop_front();
        check_out_flit("out_flit", out_flit, want);
      end else if (out_flit.src === 1'b1 && exp_q1.size() != 0) begin
        want.src  = 1'b1;
        want.data = exp_q1.pop_front();
        check_out_flit("out_flit", out_flit, want);
      end else begin
        note_failure($sformatf("output word %h came from a lane with nothing pending",
                               out_flit));
      end
    end
    // inputs are scored after outputs since a word accepted now cannot leave in the same cycle
    acc0 = in0_valid & ~in0_stall;
    acc1 = in1_valid & ~in1_stall;
    if (acc0) exp_q0.push_back(in0_flit.data);
    if (acc1) exp_q1.push_back(in1_flit.data);
    @(negedge clk);
  endtask

  task automatic drain(input string what);
    int n;
    n = 0;
    while ((exp_q0.size() != 0 || exp_q1.size() != 0) && n < DRAIN_LIMIT) begin
      tick();
      n++;
    end
    if (exp_q0.size() != 0 || exp_q1.size() != 0)
      note_failure($sformatf("%s: %0d words never came out", what,
                             exp_q0.size() + exp_q1.size()));
    repeat (3) tick();  // a late duplicate would be caught here
    check_bit("out_valid", out_valid, 1'b0);
  endtask

  // offer queued words with gaps and a random out_stall in random mode
  task automatic send_queued(input bit random_mode, input int limit);
    int          n;
    logic [31:0] r;
    n = 0;
    while ((send_q0.size() != 0 || send_q1.size() != 0) && n < limit) begin
      r = rand_next();
      if (send_q0.size() != 0 && (in0_valid || !random_mode || r[31])) begin
        in0_valid     = 1'b1;
        in0_flit.data = send_q0[0];
      end else
        in0_valid = 1'b0;
      if (send_q1.size() != 0 && (in1_valid || !random_mode || r[30])) begin
        in1_valid     = 1'b1;
        in1_flit.data = send_q1[0];
      end else
        in1_valid = 1'b0;
      if (random_mode)
        out_stall = (r[26:24] < 3'd3);  // stalled 3 cycles in 8
      tick();
      if (acc0) begin
        void'(send_q0.pop_front());
        in0_valid = 1'b0;
      end
      if (acc1) begin
        void'(send_q1.pop_front());
        in1_valid = 1'b0;
      end
      n++;
    end
    if (send_q0.size() != 0 || send_q1.size() != 0)
      note_failure($sformatf("inputs still stalled after %0d cycles", limit));
    in0_valid = 1'b0;
    in1_valid = 1'b0;
    out_stall = 1'b0;
  endtask

  task automatic test_reset_state();
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("in0_stall", in0_stall, 1'b0);
    check_bit("in1_stall", in1_stall, 1'b0);
  endtask

  task automatic test_single_word();
    int n;
    in0_valid     = 1'b1;
    in0_flit.data = rand_data();
    tick();  // accepted at this rising edge
    in0_valid = 1'b0;
    n = 0;
    while (!out_valid && n < 10) begin
      tick();
      n++;
    end
    if (!out_valid)
      note_failure("single word on lane 0 never reached the output");
    else if (n != 1)
      note_failure($sformatf("single word left at edge N+%0d instead of N+2", n + 1));
    tick();
    if (src_log.size() != 0)
      check_bit("out_flit.src", src_log[src_log.size() - 1], 1'b0);
    drain("single word test");
  endtask

  task automatic test_alternation();
    int first;
    send_q1.push_back(rand_data());  // served alone so priority returns to lane 0
    send_queued(1'b0, 20);
    drain("alternation priming");
    first = src_log.size();
    repeat (8) send_q0.push_back(rand_data());
    repeat (8) send_q1.push_back(rand_data());
    send_queued(1'b0, 100);
    drain("alternation test");
    check_int("alternation word count", src_log.size() - first, 16);
    for (int k = first; k < src_log.size(); k++)
      check_bit("out_flit.src", src_log[k], ((k - first) % 2) == 1);
  endtask

  task automatic test_backpressure();
    int accepted;
    int n;
    accepted = 0;
    n = 0;
    repeat (8) send_q0.push_back(rand_data());
    out_stall = 1'b1;
    tick();
    tick();  // stall now registered in the output buffer
    while (n < 12 && send_q0.size() != 0) begin
      in0_valid     = 1'b1;
      in0_flit.data = send_q0[0];
      tick();
      if (acc0) begin
        void'(send_q0.pop_front());
        accepted++;
      end
      n++;
    end
    // lane FIFO plus the registered arbiter stage
    check_int("words accepted under stall", accepted, `LANE_DEPTH + 1);
    check_bit("in0_stall", in0_stall, 1'b1);
    check_bit("out_valid", out_valid, 1'b0);
    out_stall = 1'b0;
    send_queued(1'b0, 60);
    drain("backpressure test");
  endtask

  task automatic test_random();
    repeat (40) send_q0.push_back(rand_data());
    repeat (40) send_q1.push_back(rand_data());
    send_queued(1'b1, 300);
    drain("random test");
  endtask

  initial begin
    err_count = 0;
    out_count = 0;
    lcg_state = 32'h10973146;
    in0_valid = 1'b0;
    in0_flit  = '0;
    in1_valid = 1'b0;
    in1_flit  = '0;
    out_stall = 1'b0;
    acc0      = 1'b0;
    acc1      = 1'b0;
    wait (rst == 1'b0);
    repeat (2) @(posedge clk);
    @(negedge clk);
    test_reset_state();
    test_single_word();
    test_alternation();
    test_backpressure();
    test_random();
    $display("errors: %0d, output words: %0d", err_count, out_count);
    if (err_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // watchdog
  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("timeout, the tests did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
    $display("errors: %0d, output words: %0d", err_count, out_count);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+.
arb_pkg.sv
stream_pkg.sv
lane_fifo.sv
stall_buf.sv
rr_arbiter.sv
lane_merge_top.sv
tb_clk_gen.sv
lane_merge_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lane_merge_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
